//--- list.f
hw/mcu_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_bus_master.sv
hw/demo_io.sv
hw/mcu_top.sv
bench/tb_clkgen.sv
bench/tb_mcu_top.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_mcu_top
FLIST = list.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_mcu_top.sv
/* mcu wrapper testbench */
`timescale 1ns/10ps

module tb_mcu_top;
  import mcu_pkg::*;

  localparam int REPLY_TIMEOUT = 40 * 10 * BAUD_DIV;  // in cycles with plenty of margin

  logic        clk, rst_n;
  logic [3:0]  sw, btn, led;
  logic        rxd, txd;
  logic [11:0] rgb;

  // register map model and pending reply bytes
  logic [7:0]  exp_q[$];
  logic [11:0] exp_gpo;
  logic [31:0] exp_scratch;
  logic [3:0]  exp_btn;
  int          errors, checks;
  int          stb_cycles, exp_strobes;
  logic        mon_en, aborted;

  tb_clkgen u_clkgen (.clk(clk), .rst_n_o(rst_n));

  mcu_top u_mcu_top (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .sw_i       (sw),
    .btn_i      (btn),
    .uart_rxd_i (rxd),
    .uart_txd_o (txd),
    .led_o      (led),
    .rgb_o      (rgb)
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  function automatic logic [3:0] led_expect(input logic [3:0] s, input logic rx,
                                            input logic tx, input logic strobe);
    return {strobe ^ ~s[3], tx ^ ~s[2], rx ^ ~s[1], s[0]};
  endfunction

  function automatic logic [31:0] ref_read(input logic [14:0] adr);
    logic [31:0] val;
    val = '0;                             // unmapped reads zero
    if (adr == REG_GPO)
      val = {20'h0, exp_gpo};
    else if (adr == REG_GPI)
      val = {28'h0, exp_btn};
    else if (adr == REG_SCRATCH)
      val = exp_scratch;
    return val;
  endfunction

  task automatic ref_write(input logic [14:0] adr, input logic [31:0] data);
    if (adr == REG_GPO)
      exp_gpo = data[11:0];
    else if (adr == REG_SCRATCH)
      exp_scratch = data;
  endtask

  // 8N1 frame sent lsb first from a falling edge
  task automatic send_byte(input logic [7:0] b);
    rxd = 1'b0;
    repeat (BAUD_DIV) @(negedge clk);
    check_value("led_o", led_expect(sw, 1'b0, 1'b1, 1'b0), led);  // rxd low, bus idle
    for (int i = 0; i < 8; i++) begin
      rxd = b[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
    rxd = 1'b1;
    repeat (BAUD_DIV) @(negedge clk);
  endtask

  task automatic wait_replies();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < REPLY_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      aborted = 1'b1;
      $display("timeout at %0t, %0d reply bytes never arrived", $time, exp_q.size());
    end else begin
      check_value("led_o[3] strobe cycles", exp_strobes, stb_cycles);
    end
  endtask

  task automatic write_cmd(input logic [15:0] adr, input logic [31:0] data);
    if (aborted)
      return;
    ref_write(adr[14:0], data);           // bit 15 ignored by the DUT
    exp_q.push_back(RSP_OK);
    exp_strobes += 2;                     // strobe high until the cycle after ack
    send_byte(CMD_WRITE);
    send_byte(adr[15:8]);
    send_byte(adr[7:0]);
    for (int i = 3; i >= 0; i--)
      send_byte(data[8*i +: 8]);          // msb first
    wait_replies();
  endtask

  task automatic read_cmd(input logic [15:0] adr);
    logic [31:0] val;
    if (aborted)
      return;
    val = ref_read(adr[14:0]);
    for (int i = 3; i >= 0; i--)
      exp_q.push_back(val[8*i +: 8]);
    exp_strobes += 2;
    send_byte(CMD_READ);
    send_byte(adr[15:8]);
    send_byte(adr[7:0]);
    wait_replies();
  endtask

  task automatic test_done(input string name, input int err_before);
    if (errors == err_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err_before);
  endtask

  // counts bus strobe cycles through led_o[3]
  always @(negedge clk) begin
    if (mon_en && led[3] !== ~sw[3])
      stb_cycles++;
  end

  // decodes reply frames and compares them with the model
  initial begin : reply_monitor
    logic [7:0] got;
    forever begin
      @(negedge clk);
      if (mon_en && !txd) begin
        repeat (BAUD_DIV / 2) @(negedge clk);   // middle of start bit
        check_value("led_o", led_expect(sw, 1'b1, 1'b0, 1'b0), led);
        for (int i = 0; i < 8; i++) begin
          repeat (BAUD_DIV) @(negedge clk);
          got[i] = txd;
        end
        repeat (BAUD_DIV) @(negedge clk);
        if (!txd) begin
          errors++;
          $display("reply frame at %0t has a low stop bit", $time);
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected reply byte %h at %0t", got, $time);
        end else begin
          check_value("uart_txd_o byte", exp_q.pop_front(), got);
        end
      end
    end
  end

  initial begin : stimulus
    int          err0, cnt;
    logic [15:0] adr;
    logic [7:0]  bad;
    sw          = '0;
    btn         = '0;
    rxd         = 1'b1;
    errors      = 0;
    checks      = 0;
    stb_cycles  = 0;
    exp_strobes = 0;
    mon_en      = 1'b0;
    aborted     = 1'b0;
    exp_gpo     = '0;
    exp_scratch = '0;
    exp_btn     = '0;
    void'($urandom(32'h6c43_ab74));

    cnt = 0;
    while (rst_n !== 1'b1 && cnt < 100) begin
      @(negedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      aborted = 1'b1;
      $display("reset never released");
    end
    repeat (4) @(negedge clk);            // internal reset is two flops late

    err0 = errors;
    check_value("rgb_o", exp_gpo, rgb);
    check_value("uart_txd_o", 32'd1, txd);
    for (int i = 0; i < 8; i++) begin
      sw = 4'($urandom);
      @(negedge clk);
      check_value("led_o", led_expect(sw, 1'b1, 1'b1, 1'b0), led);  // idle line
    end
    mon_en = 1'b1;
    test_done("reset", err0);

    err0 = errors;
    write_cmd(16'(REG_GPO), $urandom);
    check_value("rgb_o", exp_gpo, rgb);
    read_cmd(16'(REG_GPO));
    test_done("gpo", err0);

    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      adr = {1'($urandom), REG_SCRATCH};  // random bit 15
      write_cmd(adr, $urandom);
      read_cmd(16'(REG_SCRATCH));
    end
    test_done("scratch", err0);

    err0 = errors;
    for (int i = 0; i < 2; i++) begin
      btn     = 4'($urandom);
      exp_btn = btn;
      repeat (4) @(negedge clk);          // button synchronizer
      read_cmd(16'(REG_GPI));
    end
    test_done("gpi", err0);

    err0 = errors;
    adr = 16'(15'd3 + 15'($urandom % 32765));
    read_cmd(adr);
    write_cmd(adr, $urandom);
    check_value("rgb_o", exp_gpo, rgb);
    read_cmd(16'(REG_GPO));
    read_cmd(16'(REG_SCRATCH));
    test_done("unmapped", err0);

    err0 = errors;
    bad = 8'($urandom);
    if (bad == CMD_WRITE || bad == CMD_READ)
      bad = 8'h00;
    if (!aborted) begin
      exp_q.push_back(RSP_BAD);
      send_byte(bad);
      wait_replies();
    end
    read_cmd(16'(REG_SCRATCH));
    test_done("bad command", err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- bench/tb_clkgen.sv
/* testbench clock and reset */
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk,
  output logic rst_n_o
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                // 10 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_o = 1'b1;
  end

endmodule

//--- hw/mcu_top.sv
/* board wrapper, serial bus master and gpio */
`timescale 1ns/10ps

module mcu_top (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [3:0]  sw_i,
  input  logic [3:0]  btn_i,
  input  logic        uart_rxd_i,
  output logic        uart_txd_o,
  output logic [3:0]  led_o,
  output logic [11:0] rgb_o
);
  import mcu_pkg::*;

  logic             rst_meta, rst_n;      // internal reset, two flops late
  logic [7:0]       rx_data, tx_data;
  logic             rx_valid, tx_start, tx_busy;
  logic [ADR_W-1:0] adr;
  logic [DAT_W-1:0] dat_w, dat_r;
  logic             we, stb, ack;

  always_ff @(posedge clk) begin
    rst_meta <= rst_n_i;
    rst_n    <= rst_meta;
  end

  // sanity lights
  assign led_o[0] = sw_i[0];
  assign led_o[1] = uart_rxd_i ^ ~sw_i[1];
  assign led_o[2] = uart_txd_o ^ ~sw_i[2];
  assign led_o[3] = stb ^ ~sw_i[3];       // bus activity

  uart_rx u_rx (
    .clk      (clk),
    .rst_n_i  (rst_n),
    .rxd_i    (uart_rxd_i),
    .data_o   (rx_data),
    .valid_o  (rx_valid)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n_i  (rst_n),
    .data_i   (tx_data),
    .start_i  (tx_start),
    .txd_o    (uart_txd_o),
    .busy_o   (tx_busy)
  );

  uart_bus_master u_master (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .tx_data_o  (tx_data),
    .tx_start_o (tx_start),
    .tx_busy_i  (tx_busy),
    .adr_o      (adr),
    .dat_o      (dat_w),
    .dat_i      (dat_r),
    .we_o       (we),
    .stb_o      (stb),
    .ack_i      (ack)
  );

  demo_io u_io (
    .clk      (clk),
    .rst_n_i  (rst_n),
    .adr_i    (adr),
    .dat_i    (dat_w),
    .dat_o    (dat_r),
    .we_i     (we),
    .stb_i    (stb),
    .ack_o    (ack),
    .gp_o     (rgb_o),                    // rgb groups 0..3
    .gp_i     (btn_i)
  );

endmodule

//--- hw/demo_io.sv
/* gpio and scratch bus slave */
`timescale 1ns/10ps

module demo_io (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [mcu_pkg::ADR_W-1:0] adr_i,
  input  logic [mcu_pkg::DAT_W-1:0] dat_i,
  output logic [mcu_pkg::DAT_W-1:0] dat_o,
  input  logic                      we_i,
  input  logic                      stb_i,
  output logic                      ack_o,
  output logic [mcu_pkg::GPO_W-1:0] gp_o,
  input  logic [mcu_pkg::GPI_W-1:0] gp_i
);
  import mcu_pkg::*;

  logic [GPI_W-1:0] gpi_meta, gpi_sync;
  logic [DAT_W-1:0] scratch;
  logic [DAT_W-1:0] rd_mux;
  logic             req;

  assign req = stb_i && !ack_o;           // first cycle of a strobe

  // buttons are asynchronous to clk
  always_ff @(posedge clk) begin
    gpi_meta <= gp_i;
    gpi_sync <= gpi_meta;
  end

  always_comb begin
    case (adr_i)
      REG_GPO:     rd_mux = {{(DAT_W - GPO_W){1'b0}}, gp_o};
      REG_GPI:     rd_mux = {{(DAT_W - GPI_W){1'b0}}, gpi_sync};
      REG_SCRATCH: rd_mux = scratch;
      default:     rd_mux = '0;           // unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_o   <= 1'b0;
      gp_o    <= '0;
      scratch <= '0;
    end else begin
      ack_o <= req;                       // single cycle ack
      if (req && we_i) begin
        case (adr_i)
          REG_GPO:     gp_o    <= dat_i[GPO_W-1:0];
          REG_SCRATCH: scratch <= dat_i;
          default:     ;                  // read only or unmapped
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req)
      dat_o <= rd_mux;
  end

  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (!rst_n_i) ack_o |-> stb_i);

endmodule

//--- hw/uart_bus_master.sv
/* serial command parser, bus master */
`timescale 1ns/10ps

module uart_bus_master (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [7:0]                rx_data_i,
  input  logic                      rx_valid_i,
  output logic [7:0]                tx_data_o,
  output logic                      tx_start_o,
  input  logic                      tx_busy_i,
  output logic [mcu_pkg::ADR_W-1:0] adr_o,
  output logic [mcu_pkg::DAT_W-1:0] dat_o,
  input  logic [mcu_pkg::DAT_W-1:0] dat_i,
  output logic                      we_o,
  output logic                      stb_o,
  input  logic                      ack_i
);
  import mcu_pkg::*;

  master_state_e    state;
  cmd_op_e          cmd;
  logic [1:0]       byte_cnt;             // bytes left minus one
  logic [DAT_W-1:0] rsp_sr;               // reply bytes, msb first

  assign cmd = cmd_op_e'(rx_data_i);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state      <= M_IDLE;
      stb_o      <= 1'b0;
      we_o       <= 1'b0;
      tx_start_o <= 1'b0;
      byte_cnt   <= '0;
    end else begin
      tx_start_o <= 1'b0;
      case (state)
        M_IDLE: if (rx_valid_i) begin
          case (cmd)
            CMD_WRITE: begin
              we_o  <= 1'b1;
              state <= M_ADR_HI;
            end
            CMD_READ: begin
              we_o  <= 1'b0;
              state <= M_ADR_HI;
            end
            default: begin
              rsp_sr   <= {RSP_BAD, {(DAT_W - 8){1'b0}}};
              byte_cnt <= 2'd0;
              state    <= M_REPLY;
            end
          endcase
        end
        M_ADR_HI: if (rx_valid_i) begin
          adr_o[ADR_W-1:8] <= rx_data_i[ADR_W-9:0];  // top bit dropped
          state            <= M_ADR_LO;
        end
        M_ADR_LO: if (rx_valid_i) begin
          adr_o[7:0] <= rx_data_i;
          if (we_o) begin
            byte_cnt <= 2'd3;
            state    <= M_DATA;
          end else begin
            stb_o <= 1'b1;                // read goes straight to the bus
            state <= M_BUS;
          end
        end
        M_DATA: if (rx_valid_i) begin
          dat_o    <= {dat_o[DAT_W-9:0], rx_data_i};
          byte_cnt <= byte_cnt - 1'b1;
          if (byte_cnt == 2'd0) begin
            stb_o <= 1'b1;
            state <= M_BUS;
          end
        end
        M_BUS: if (ack_i) begin
          stb_o <= 1'b0;
          state <= M_REPLY;
          if (we_o) begin
            rsp_sr   <= {RSP_OK, {(DAT_W - 8){1'b0}}};
            byte_cnt <= 2'd0;
          end else begin
            rsp_sr   <= dat_i;            // read data valid with ack
            byte_cnt <= 2'd3;
          end
        end
        M_REPLY: if (!tx_busy_i && !tx_start_o) begin
          // busy shows up one cycle after start, hence the start check
          tx_data_o  <= rsp_sr[DAT_W-1:DAT_W-8];
          tx_start_o <= 1'b1;
          rsp_sr     <= {rsp_sr[DAT_W-9:0], 8'h00};
          if (byte_cnt == 2'd0)
            state <= M_IDLE;
          else
            byte_cnt <= byte_cnt - 1'b1;
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  // request must not move while the slave has yet to answer
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (stb_o && !ack_i) |=> ($stable(adr_o) && $stable(we_o) && $stable(dat_o)));

endmodule

//--- hw/uart_tx.sv
/* uart transmitter, 8N1 */
`timescale 1ns/10ps

module uart_tx (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic [7:0] data_i,
  input  logic       start_i,
  output logic       txd_o,
  output logic       busy_o
);
  import mcu_pkg::*;

  rx_state_e             state;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [2:0]            bit_cnt;
  logic [7:0]            shift;
  logic                  tick;

  assign tick = (baud_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state    <= RX_IDLE;
      txd_o    <= 1'b1;                   // line idles high
      busy_o   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      if (state != RX_IDLE)
        baud_cnt <= tick ? BAUD_CNT_W'(BAUD_DIV - 1) : baud_cnt - 1'b1;
      case (state)
        RX_IDLE: if (start_i) begin
          shift    <= data_i;
          txd_o    <= 1'b0;               // start bit
          busy_o   <= 1'b1;
          baud_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
          state    <= RX_START;
        end
        RX_START: if (tick) begin
          txd_o   <= shift[0];
          bit_cnt <= '0;
          state   <= RX_DATA;
        end
        RX_DATA: if (tick) begin
          if (bit_cnt == 3'd7) begin
            txd_o <= 1'b1;                // stop bit
            state <= RX_STOP;
          end else begin
            txd_o   <= shift[1];
            shift   <= {1'b0, shift[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        RX_STOP: if (tick) begin
          busy_o <= 1'b0;
          state  <= RX_IDLE;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // the master must wait for busy to clear before the next byte
  a_no_start_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n_i) !(start_i && busy_o));

endmodule

//--- hw/uart_rx.sv
/* uart receiver, 8N1 */
`timescale 1ns/10ps

module uart_rx (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       rxd_i,
  output logic [7:0] data_o,
  output logic       valid_o
);
  import mcu_pkg::*;

  rx_state_e             state;
  logic                  rxd_meta, rxd_sync, rxd_prev;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [2:0]            bit_cnt;
  logic [7:0]            shift;
  logic                  tick;

  assign tick = (baud_cnt == '0);

  // two flops against metastability, third for edge detect
  always_ff @(posedge clk) begin
    rxd_meta <= rxd_i;
    rxd_sync <= rxd_meta;
    rxd_prev <= rxd_sync;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state    <= RX_IDLE;
      valid_o  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      valid_o <= 1'b0;
      if (state != RX_IDLE)
        baud_cnt <= tick ? BAUD_CNT_W'(BAUD_DIV - 1) : baud_cnt - 1'b1;
      case (state)
        RX_IDLE: if (rxd_prev && !rxd_sync) begin
          state    <= RX_START;
          baud_cnt <= BAUD_CNT_W'(BAUD_DIV / 2 - 1);  // aim at mid start bit
        end
        RX_START: if (tick) begin
          if (!rxd_sync) begin
            state   <= RX_DATA;
            bit_cnt <= '0;
          end else begin
            state <= RX_IDLE;             // glitch, not a start bit
          end
        end
        RX_DATA: if (tick) begin
          shift   <= {rxd_sync, shift[7:1]};  // lsb first
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7)
            state <= RX_STOP;
        end
        RX_STOP: if (tick) begin
          state <= RX_IDLE;
          if (rxd_sync) begin             // framing error drops the byte
            data_o  <= shift;
            valid_o <= 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

//--- hw/mcu_pkg.sv
/* mcu wrapper shared definitions */

package mcu_pkg;

  // bus geometry
  localparam int ADR_W = 15;              // word address
  localparam int DAT_W = 32;
  localparam int GPO_W = 12;              // four rgb groups
  localparam int GPI_W = 4;               // pushbuttons

  // serial line
  localparam int BAUD_DIV   = 8;          // clocks per bit, fast for sim
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

  // register map
  localparam logic [ADR_W-1:0] REG_GPO     = ADR_W'(0);
  localparam logic [ADR_W-1:0] REG_GPI     = ADR_W'(1);
  localparam logic [ADR_W-1:0] REG_SCRATCH = ADR_W'(2);

  // host command and reply bytes
  typedef enum logic [7:0] {
    CMD_WRITE = 8'h57,                    // 'W'
    CMD_READ  = 8'h52,                    // 'R'
    RSP_OK    = 8'h4B,                    // 'K'
    RSP_BAD   = 8'h3F                     // '?'
  } cmd_op_e;

  typedef enum logic [2:0] {
    M_IDLE,
    M_ADR_HI,
    M_ADR_LO,
    M_DATA,
    M_BUS,
    M_REPLY
  } master_state_e;

  // shared by receiver and transmitter
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage
